// File: design/cdb_tag_match.sv
`timescale 1ns/1ps

// Wakeup compare between every table entry and the broadcast buses
module cdb_tag_match
    import mt_pkg::*;
(
    input  map_entry_t [NUM_MAP_ENTRIES-1:0] entries,   // Current table
    input  cdb_t       [NUM_CDB-1:0]         cdb,       // Broadcasts this cycle
    output logic       [NUM_MAP_ENTRIES-1:0] cdb_hit    // Entry producer is on a bus
);

    logic [NUM_CDB-1:0] bus_match [NUM_MAP_ENTRIES];    // Per entry, per bus compare

    // Full tag compare matrix
    always_comb begin
        for (int e = 0; e < NUM_MAP_ENTRIES; e++) begin
            for (int c = 0; c < NUM_CDB; c++) begin
                bus_match[e][c] = cdb[c].valid && (cdb[c].tag == entries[e].tag);
            end
        end
    end

    // Only mapped entries can wake up, so a stale tag 0 never hits
    always_comb begin
        for (int e = 0; e < NUM_MAP_ENTRIES; e++) begin
            cdb_hit[e] = entries[e].mapped && (|bus_match[e]);
        end
    end

endmodule

// File: design/map_entry_array.sv
`timescale 1ns/1ps

// Register storage of the map table, index is register number minus one
module map_entry_array
    import mt_pkg::*;
(
    input  logic                                clock,
    input  logic                                rst_n,
    input  logic                                squash,     // Flush all renames
    input  logic          [NUM_MAP_ENTRIES-1:0] cdb_hit,    // Wakeups this cycle
    input  rename_write_t [NUM_WAYS-1:0]        writes,     // Destination updates in order
    output map_entry_t    [NUM_MAP_ENTRIES-1:0] entries     // Registered table
);

    map_entry_t [NUM_MAP_ENTRIES-1:0] entries_next;         // Table after this cycle
    logic       [NUM_MAP_ENTRIES-1:0] write_hit;            // Entry renamed this cycle
    rob_tag_t   [NUM_MAP_ENTRIES-1:0] write_tag;            // Winning tag per entry

    // Pick the last enabled way per register
    always_comb begin
        for (int e = 0; e < NUM_MAP_ENTRIES; e++) begin
            write_hit[e] = 1'b0;
            write_tag[e] = '0;
            for (int w = 0; w < NUM_WAYS; w++) begin
                if (writes[w].en && (writes[w].rd == arch_reg_t'(e + 1))) begin
                    write_hit[e] = 1'b1;                    // Later ways overwrite
                    write_tag[e] = writes[w].tag;
                end
            end
        end
    end

    // Rename beats wakeup, wakeup beats hold
    always_comb begin
        for (int e = 0; e < NUM_MAP_ENTRIES; e++) begin
            entries_next[e] = entries[e];
            if (write_hit[e]) begin
                entries_next[e].tag    = write_tag[e];
                entries_next[e].ready  = 1'b0;              // New producer not done yet
                entries_next[e].mapped = 1'b1;
            end else if (cdb_hit[e]) begin
                entries_next[e].ready  = 1'b1;              // Tag and mapped unchanged
            end
        end
    end

    // Squash has top priority and lands on the next edge
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            entries <= '0;                                  // All registers in ARF
        end else if (squash) begin
            entries <= '0;                                  // Back to precise state
        end else begin
            entries <= entries_next;
        end
    end

endmodule

// File: design/map_table_top.sv
`timescale 1ns/1ps

// Register map table for a three-wide ROB-renaming core
module map_table_top
    import mt_pkg::*;
(
    input  logic                         clock,
    input  logic                         rst_n,
    input  logic                         squash,     // Flush, applied on next edge
    input  dispatch_way_t [NUM_WAYS-1:0] dispatch,   // Dispatch group
    input  cdb_t          [NUM_CDB-1:0]  cdb,        // Result broadcasts
    output src_tags_t     [NUM_WAYS-1:0] src_tags    // Combinational source answers
);

    map_entry_t    [NUM_MAP_ENTRIES-1:0] entries;    // Registered table
    logic          [NUM_MAP_ENTRIES-1:0] cdb_hit;    // Wakeup per entry
    rename_write_t [NUM_WAYS-1:0]        writes;     // Destination renames

    // Wakeup compare
    cdb_tag_match u_cdb_tag_match (
        .entries (entries),
        .cdb     (cdb),
        .cdb_hit (cdb_hit)
    );

    // Source lookup and rename generation
    rename_lookup u_rename_lookup (
        .entries  (entries),
        .cdb_hit  (cdb_hit),
        .dispatch (dispatch),
        .src_tags (src_tags),
        .writes   (writes)
    );

    // Table state
    map_entry_array u_map_entry_array (
        .clock   (clock),
        .rst_n   (rst_n),
        .squash  (squash),
        .cdb_hit (cdb_hit),
        .writes  (writes),
        .entries (entries)
    );

endmodule

// File: design/mt_pkg.sv
package mt_pkg;

    // Core sizing
    localparam int NUM_WAYS        = 3;                   // Dispatch width
    localparam int NUM_CDB         = 3;                   // Result broadcast buses
    localparam int NUM_ARCH_REGS   = 32;                  // x0..x31
    localparam int NUM_MAP_ENTRIES = NUM_ARCH_REGS - 1;   // x0 never renamed
    localparam int ROB_LEN         = 32;                  // Reorder buffer depth

    // Derived widths
    localparam int REG_W = $clog2(NUM_ARCH_REGS);         // Arch register index
    localparam int TAG_W = $clog2(ROB_LEN);               // ROB slot index

    typedef logic [REG_W-1:0] arch_reg_t;                 // Architectural register number
    typedef logic [TAG_W-1:0] rob_tag_t;                  // Reorder buffer tag

    // One instruction from dispatch, rd of 0 means no destination
    typedef struct packed {
        logic      valid;                                 // Slot holds an instruction
        arch_reg_t rd;                                    // Destination
        arch_reg_t rs1;                                   // First source
        arch_reg_t rs2;                                   // Second source
        rob_tag_t  tag;                                   // Own ROB slot
    } dispatch_way_t;

    // One result broadcast
    typedef struct packed {
        logic     valid;                                  // Bus carries a result
        rob_tag_t tag;                                    // Producer slot
    } cdb_t;

    // Table entry for one register
    typedef struct packed {
        rob_tag_t tag;                                    // Latest producer
        logic     ready;                                  // Producer already broadcast
        logic     mapped;                                 // In-flight producer exists
    } map_entry_t;

    // Destination update from one way
    typedef struct packed {
        logic      en;                                    // Apply this write
        arch_reg_t rd;                                    // Register being renamed
        rob_tag_t  tag;                                   // New producer
    } rename_write_t;

    // Source answer for one way
    typedef struct packed {
        rob_tag_t t1;                                     // Producer of rs1
        rob_tag_t t2;                                     // Producer of rs2
        logic     t1_ready;                               // rs1 value available in ROB
        logic     t2_ready;                               // rs2 value available in ROB
        logic     t1_mapped;                              // rs1 comes from ROB, else ARF
        logic     t2_mapped;                              // rs2 comes from ROB, else ARF
    } src_tags_t;

endpackage

// File: design/rename_lookup.sv
`timescale 1ns/1ps

// Source operand lookup for a dispatch group plus destination rename requests
module rename_lookup
    import mt_pkg::*;
(
    input  map_entry_t    [NUM_MAP_ENTRIES-1:0] entries,    // Registered table
    input  logic          [NUM_MAP_ENTRIES-1:0] cdb_hit,    // Same-cycle wakeups
    input  dispatch_way_t [NUM_WAYS-1:0]        dispatch,   // Group in program order
    output src_tags_t     [NUM_WAYS-1:0]        src_tags,   // Answer per way
    output rename_write_t [NUM_WAYS-1:0]        writes      // Destination updates
);

    // Destination requests, only valid ways with a real rd
    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            writes[w].en  = dispatch[w].valid && (dispatch[w].rd != '0);
            writes[w].rd  = dispatch[w].rd;
            writes[w].tag = dispatch[w].tag;
        end
    end

    // Table read with bypass from older ways of the same group
    function automatic map_entry_t read_src(
        input map_entry_t    [NUM_MAP_ENTRIES-1:0] tbl,
        input logic          [NUM_MAP_ENTRIES-1:0] hit,
        input rename_write_t [NUM_WAYS-1:0]        wr,
        input arch_reg_t                           src,
        input int                                  way
    );
        map_entry_t res;
        res = '0;                                           // x0 reads as unmapped
        if (src != '0) begin
            res       = tbl[src - 1];
            res.ready = tbl[src - 1].ready | hit[src - 1];  // Broadcast seen this cycle
            for (int j = 0; j < NUM_WAYS; j++) begin
                if ((j < way) && wr[j].en && (wr[j].rd == src)) begin
                    res.tag    = wr[j].tag;                 // Youngest older writer wins
                    res.ready  = 1'b0;
                    res.mapped = 1'b1;
                end
            end
        end
        return res;
    endfunction

    // Pack both operands per way
    always_comb begin
        map_entry_t op1;
        map_entry_t op2;
        for (int w = 0; w < NUM_WAYS; w++) begin
            op1 = read_src(entries, cdb_hit, writes, dispatch[w].rs1, w);
            op2 = read_src(entries, cdb_hit, writes, dispatch[w].rs2, w);
            if (dispatch[w].valid) begin
                src_tags[w].t1        = op1.tag;
                src_tags[w].t2        = op2.tag;
                src_tags[w].t1_ready  = op1.ready;
                src_tags[w].t2_ready  = op2.ready;
                src_tags[w].t1_mapped = op1.mapped;
                src_tags[w].t2_mapped = op2.mapped;
            end else begin
                src_tags[w] = '0;                           // Empty slot answers nothing
            end
        end
    end

endmodule

// File: map_table_top.f
design/mt_pkg.sv
design/cdb_tag_match.sv
design/map_entry_array.sv
design/rename_lookup.sv
design/map_table_top.sv
sim/clock_gen.sv
sim/map_table_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the map table testbench with Verilator

cd "$(dirname "$0")" || exit 1

TOP=map_table_tb
BUILD_DIR=obj_dir
LOG_FILE=sim_run.log

# Compile RTL and testbench into one executable
verilator --binary --timing --assert -Wno-fatal \
    --top-module "$TOP" \
    -f map_table_top.f \
    --Mdir "$BUILD_DIR" \
    -o "$TOP"
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

# Run the simulation and keep its output
"./$BUILD_DIR/$TOP" > "$LOG_FILE" 2>&1
status=$?
cat "$LOG_FILE"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

# The verdict comes from the log
if grep -q '^>>> PASS$' "$LOG_FILE"; then
    echo "Simulation passed, log in $LOG_FILE"
    exit 0
fi
echo "Pass message not found in $LOG_FILE"
exit 1

// File: sim/clock_gen.sv
`timescale 1ns/1ps

// Testbench clock and power-on reset
module clock_gen (
    output logic clock,
    output logic rst_n
);

    // 40 ns period, starts low
    initial begin
        clock = 1'b0;
        forever begin
            #20 clock = ~clock;                 // Half period
        end
    end

    // Reset held over the first four clock cycles
    initial begin
        rst_n = 1'b0;
        repeat (4) @(negedge clock);
        rst_n = 1'b1;                           // Released on a falling edge
    end

endmodule

// File: sim/map_table_tb.sv
`timescale 1ns/1ps

// Vector driven testbench for the register map table
module map_table_tb
    import mt_pkg::*;
();

    // One cycle of stimulus together with its expected answer
    typedef struct packed {
        logic                         squash;
        dispatch_way_t [NUM_WAYS-1:0] dispatch;
        cdb_t          [NUM_CDB-1:0]  cdb;
        src_tags_t     [NUM_WAYS-1:0] expect_tags;
    } vector_t;

    logic                         clock;
    logic                         rst_n;
    logic                         squash;
    dispatch_way_t [NUM_WAYS-1:0] dispatch;
    cdb_t          [NUM_CDB-1:0]  cdb;
    src_tags_t     [NUM_WAYS-1:0] src_tags;

    vector_t vectors [$];                       // Whole vector file
    int      tokens  [$];                       // Numbers of the current line
    bit      bad_char    = 1'b0;                // Line holds an unexpected character
    int      cycle_count = 0;                   // Rising edges since time 0
    int      cycle_limit = 0;                   // Set once the vectors are known

    clock_gen u_clock_gen (
        .clock (clock),
        .rst_n (rst_n)
    );

    map_table_top u_map_table_top (
        .clock    (clock),
        .rst_n    (rst_n),
        .squash   (squash),
        .dispatch (dispatch),
        .cdb      (cdb),
        .src_tags (src_tags)
    );

    // Squash plus five fields per way, two per bus and six expected per way
    function automatic int line_field_count();
        return 1 + 5 * NUM_WAYS + 2 * NUM_CDB + 6 * NUM_WAYS;
    endfunction

    task automatic abort_run();
        $display(">>> FAIL");
        $fatal(1, "run aborted");
    endtask

    // Split a line into decimal numbers with '|' and blanks between them and '#' opening a comment
    task automatic tokenize_line(input string line);
        logic [7:0] ch;
        int         start;
        string      word;
        tokens.delete();
        bad_char = 1'b0;
        start    = -1;
        for (int i = 0; i <= line.len(); i++) begin
            ch = (i < line.len()) ? line.getc(i) : 8'h20;   // Virtual blank ends last number
            if (ch >= "0" && ch <= "9") begin
                if (start < 0) begin
                    start = i;
                end
            end else begin
                if (start >= 0) begin
                    word = line.substr(start, i - 1);
                    tokens.push_back(word.atoi());
                    start = -1;
                end
                if (ch == "#") begin
                    break;                                  // Rest is comment
                end
                if (!(ch == " " || ch == "|" || ch == 8'h09 || ch == 8'h0a || ch == 8'h0d)) begin
                    bad_char = 1'b1;
                end
            end
        end
    endtask

    // Register numbers and tags stay below 32
    function automatic bit tokens_in_range();
        bit ok;
        ok = 1'b1;
        foreach (tokens[k]) begin
            if (tokens[k] > 31) begin
                ok = 1'b0;
            end
        end
        return ok;
    endfunction

    function automatic vector_t build_vector();
        vector_t vec;
        int      base;
        vec        = '0;
        vec.squash = tokens[0][0];
        for (int w = 0; w < NUM_WAYS; w++) begin
            base                  = 1 + 5 * w;
            vec.dispatch[w].valid = tokens[base][0];
            vec.dispatch[w].rd    = arch_reg_t'(tokens[base + 1]);
            vec.dispatch[w].rs1   = arch_reg_t'(tokens[base + 2]);
            vec.dispatch[w].rs2   = arch_reg_t'(tokens[base + 3]);
            vec.dispatch[w].tag   = rob_tag_t'(tokens[base + 4]);
        end
        for (int c = 0; c < NUM_CDB; c++) begin
            base             = 1 + 5 * NUM_WAYS + 2 * c;
            vec.cdb[c].valid = tokens[base][0];
            vec.cdb[c].tag   = rob_tag_t'(tokens[base + 1]);
        end
        for (int w = 0; w < NUM_WAYS; w++) begin
            base                          = 1 + 5 * NUM_WAYS + 2 * NUM_CDB + 6 * w;
            vec.expect_tags[w].t1         = rob_tag_t'(tokens[base]);
            vec.expect_tags[w].t2         = rob_tag_t'(tokens[base + 1]);
            vec.expect_tags[w].t1_ready   = tokens[base + 2][0];
            vec.expect_tags[w].t2_ready   = tokens[base + 3][0];
            vec.expect_tags[w].t1_mapped  = tokens[base + 4][0];
            vec.expect_tags[w].t2_mapped  = tokens[base + 5][0];
        end
        return vec;
    endfunction

    task automatic load_vectors();
        int    fd;
        int    line_no;
        string line;
        fd = $fopen("sim/mt_input_vectors.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the vector file sim/mt_input_vectors.txt");
            abort_run();
        end else begin
            line_no = 0;
            while ($fgets(line, fd) != 0) begin
                line_no++;
                tokenize_line(line);
                if (bad_char || !(tokens.size() == 0 ||
                    (tokens.size() == line_field_count() && tokens_in_range()))) begin
                    $display("Line %0d of the vector file is malformed", line_no);
                    abort_run();
                end else if (tokens.size() != 0) begin
                    vectors.push_back(build_vector());      // Blank and comment lines skipped
                end
            end
            $fclose(fd);
            if (vectors.size() == 0) begin
                $display("The vector file holds no vectors");
                abort_run();
            end
        end
    endtask

    task automatic apply_vector(input vector_t vec);
        squash   = vec.squash;
        dispatch = vec.dispatch;
        cdb      = vec.cdb;
    endtask

    task automatic check_field(input int vec_idx, input int way, input string field,
                               input int expected, input int actual);
        assert (actual == expected) else begin
            $display("error: time %0t vector %0d way %0d field %s expected %0d got %0d",
                     $time, vec_idx, way, field, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_vector(input int vec_idx, input vector_t vec);
        src_tags_t exp_t;
        src_tags_t got_t;
        for (int w = 0; w < NUM_WAYS; w++) begin
            exp_t = vec.expect_tags[w];
            got_t = src_tags[w];
            check_field(vec_idx, w, "t1", int'(exp_t.t1), int'(got_t.t1));
            check_field(vec_idx, w, "t2", int'(exp_t.t2), int'(got_t.t2));
            check_field(vec_idx, w, "t1_ready", int'(exp_t.t1_ready), int'(got_t.t1_ready));
            check_field(vec_idx, w, "t2_ready", int'(exp_t.t2_ready), int'(got_t.t2_ready));
            check_field(vec_idx, w, "t1_mapped", int'(exp_t.t1_mapped), int'(got_t.t1_mapped));
            check_field(vec_idx, w, "t2_mapped", int'(exp_t.t2_mapped), int'(got_t.t2_mapped));
        end
    endtask

    // Run length bounded by the vector count
    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout after %0d cycles, the vector sequence did not finish", cycle_count);
            abort_run();
        end
    end

    initial begin
        squash   = 1'b0;
        dispatch = '0;
        cdb      = '0;
        load_vectors();
        cycle_limit = vectors.size() + 20;          // Reset and margin
        wait (rst_n === 1'b1);
        foreach (vectors[i]) begin
            @(negedge clock);
            apply_vector(vectors[i]);
            #5;                                     // Combinational answer settled
            check_vector(i, vectors[i]);
        end
        $display(">>> PASS");
        $finish;
    end

endmodule

// File: sim/mt_input_vectors.txt
# sq | way0..2: valid rd rs1 rs2 tag | cdb0..2: valid tag (x3) | expected per way:
# t1 t2 t1_ready t2_ready t1_mapped t2_mapped, all decimal, one line per cycle

# Empty table after reset
0 | 1 0 1 2 0 | 1 0 5 31 1 | 1 0 0 7 2 | 0 0 0 0 0 0 | 0 0 0 0 0 0 | 0 0 0 0 0 0 | 0 0 0 0 0 0
0 | 0 0 0 0 0 | 0 3 4 5 6 | 0 0 0 0 0 | 0 0 0 0 0 0 | 0 0 0 0 0 0 | 0 0 0 0 0 0 | 0 0 0 0 0 0

# Single rename, then read in a later cycle
0 | 1 5 0 0 3 | 0 0 0 0 0 | 0 0 0 0 0 | 0 0 0 0 0 0 | 0 0 0 0 0 0 | 0 0 0 0 0 0 | 0 0 0 0 0 0
0 | 1 0 5 0 4 | 1 0 0 5 5 | 0 0 0 0 0 | 0 0 0 0 0 0 | 3 0 0 0 1 0 | 0 3 0 0 0 1 | 0 0 0 0 0 0

# Broadcast wakeup, same cycle and later, tag 0 on an empty entry
0 | 1 0 5 5 6 | 0 0 0 0 0 | 0 0 0 0 0 | 1 3 0 0 0 0 | 3 3 1 1 1 1 | 0 0 0 0 0 0 | 0 0 0 0 0 0
0 | 1 0 5 0 7 | 1 0 1 2 8 | 0 0 0 0 0 | 0 0 1 0 0 0 | 3 0 1 0 1 0 | 0 0 0 0 0 0 | 0 0 0 0 0 0

# In-group forwarding and last writer wins
0 | 1 6 5 0 9 | 1 7 6 5 10 | 1 8 7 6 11 | 0 0 0 0 0 0 | 3 0 1 0 1 0 | 9 3 0 1 1 1 | 10 9 0 0 1 1
0 | 1 9 0 0 12 | 1 0 9 0 13 | 1 9 9 0 14 | 0 0 0 0 0 0 | 0 0 0 0 0 0 | 12 0 0 0 1 0 | 12 0 0 0 1 0
0 | 1 0 9 8 15 | 1 0 7 6 16 | 0 0 0 0 0 | 0 0 0 0 1 11 | 14 11 0 1 1 1 | 10 9 0 0 1 1 | 0 0 0 0 0 0
0 | 1 10 8 0 17 | 1 10 0 0 18 | 1 0 10 8 19 | 0 0 0 0 0 0 | 11 0 1 0 1 0 | 0 0 0 0 0 0 | 18 11 0 1 1 1

# Rename beats wakeup of the old producer
0 | 1 10 10 0 20 | 0 0 0 0 0 | 0 0 0 0 0 | 1 18 0 0 0 0 | 18 0 1 0 1 0 | 0 0 0 0 0 0 | 0 0 0 0 0 0
0 | 1 0 10 0 21 | 0 0 0 0 0 | 0 0 0 0 0 | 0 0 0 0 0 0 | 20 0 0 0 1 0 | 0 0 0 0 0 0 | 0 0 0 0 0 0

# A way never sees its own rename, invalid ways never write
0 | 1 11 11 0 22 | 1 0 11 0 23 | 0 0 0 0 0 | 0 0 0 0 0 0 | 0 0 0 0 0 0 | 22 0 0 0 1 0 | 0 0 0 0 0 0
0 | 0 12 0 0 24 | 1 0 12 11 25 | 0 0 0 0 0 | 0 0 0 0 0 0 | 0 0 0 0 0 0 | 0 22 0 0 0 1 | 0 0 0 0 0 0
0 | 1 0 12 0 26 | 0 0 0 0 0 | 0 0 0 0 0 | 0 0 0 0 0 0 | 0 0 0 0 0 0 | 0 0 0 0 0 0 | 0 0 0 0 0 0

# Squash keeps current answers, clears on the next edge
1 | 1 0 5 6 27 | 1 13 0 0 28 | 0 0 0 0 0 | 0 0 1 9 0 0 | 3 9 1 1 1 1 | 0 0 0 0 0 0 | 0 0 0 0 0 0
0 | 1 0 5 6 29 | 1 0 13 10 30 | 1 0 8 11 31 | 0 0 0 0 0 0 | 0 0 0 0 0 0 | 0 0 0 0 0 0 | 0 0 0 0 0 0

# Renaming works again, tag 0 as a real producer
0 | 1 5 0 0 0 | 1 0 5 0 1 | 0 0 0 0 0 | 0 0 0 0 0 0 | 0 0 0 0 0 0 | 0 0 0 0 1 0 | 0 0 0 0 0 0
0 | 1 0 5 0 2 | 0 0 0 0 0 | 0 0 0 0 0 | 0 0 0 0 0 0 | 0 0 0 0 1 0 | 0 0 0 0 0 0 | 0 0 0 0 0 0
0 | 1 0 5 5 3 | 0 0 0 0 0 | 0 0 0 0 0 | 0 0 0 0 1 0 | 0 0 1 1 1 1 | 0 0 0 0 0 0 | 0 0 0 0 0 0
0 | 1 0 5 0 4 | 1 6 0 0 5 | 1 0 6 0 6 | 0 0 0 0 0 0 | 0 0 1 0 1 0 | 0 0 0 0 0 0 | 5 0 0 0 1 0
1 | 1 0 6 0 7 | 0 0 0 0 0 | 0 0 0 0 0 | 0 0 0 0 0 0 | 5 0 0 0 1 0 | 0 0 0 0 0 0 | 0 0 0 0 0 0
0 | 1 0 6 5 8 | 0 0 0 0 0 | 0 0 0 0 0 | 0 0 0 0 0 0 | 0 0 0 0 0 0 | 0 0 0 0 0 0 | 0 0 0 0 0 0
0 | 0 0 0 0 0 | 0 0 0 0 0 | 0 0 0 0 0 | 0 0 0 0 0 0 | 0 0 0 0 0 0 | 0 0 0 0 0 0 | 0 0 0 0 0 0

# Edge registers and all three buses at once
0 | 1 31 0 0 12 | 1 1 31 0 13 | 1 2 1 31 14 | 0 0 0 0 0 0 | 0 0 0 0 0 0 | 12 0 0 0 1 0 | 13 12 0 0 1 1
0 | 1 0 31 1 15 | 1 0 2 0 16 | 0 0 0 0 0 | 1 12 1 13 1 14 | 12 13 1 1 1 1 | 14 0 1 0 1 0 | 0 0 0 0 0 0
0 | 1 0 1 2 17 | 0 0 1 2 19 | 1 0 31 31 18 | 0 0 0 0 0 0 | 13 14 1 1 1 1 | 0 0 0 0 0 0 | 12 12 1 1 1 1

# Stale broadcast of a replaced producer does not wake
0 | 1 1 1 0 20 | 1 0 1 0 21 | 0 0 0 0 0 | 0 0 1 13 0 0 | 13 0 1 0 1 0 | 20 0 0 0 1 0 | 0 0 0 0 0 0
0 | 1 0 1 0 22 | 0 0 0 0 0 | 0 0 0 0 0 | 1 13 0 0 0 0 | 20 0 0 0 1 0 | 0 0 0 0 0 0 | 0 0 0 0 0 0
0 | 1 0 1 0 23 | 0 0 0 0 0 | 0 0 0 0 0 | 0 0 0 0 1 20 | 20 0 1 0 1 0 | 0 0 0 0 0 0 | 0 0 0 0 0 0

# Squash drops a rename of the same cycle
1 | 1 3 1 0 24 | 0 0 0 0 0 | 0 0 0 0 0 | 0 0 0 0 0 0 | 20 0 1 0 1 0 | 0 0 0 0 0 0 | 0 0 0 0 0 0
0 | 1 0 1 3 25 | 1 0 31 2 26 | 0 0 0 0 0 | 0 0 0 0 0 0 | 0 0 0 0 0 0 | 0 0 0 0 0 0 | 0 0 0 0 0 0
